// ==== src.f ====
hw/tcp_pkg.sv
hw/inet_checksum.sv
hw/tcp_port_table.sv
hw/tcp_rx_parser.sv
hw/tcp_reply_tx.sv
hw/tcp_syn_responder.sv
test/tcp_syn_responder_sva.sv
test/tcp_syn_responder_tb.sv

// ==== Bender.yml ====
package:
  name: tcp_syn_responder

sources:
  - hw/tcp_pkg.sv
  - hw/inet_checksum.sv
  - hw/tcp_port_table.sv
  - hw/tcp_rx_parser.sv
  - hw/tcp_reply_tx.sv
  - hw/tcp_syn_responder.sv
  - target: test
    files:
      - test/tcp_syn_responder_sva.sv
      - test/tcp_syn_responder_tb.sv

// ==== test/tcp_syn_responder_tb.sv ====
`timescale 1ns/10ps

module tcp_syn_responder_tb import tcp_pkg::*; ();

	localparam int   CLK_PERIOD   = 20;
	localparam int   RST_CYCLES   = 16;
	localparam int   NUM_DIRECTED = 13;
	localparam int   NUM_RAND     = 80;
	localparam int   NUM_SEGS     = NUM_DIRECTED + NUM_RAND;
	localparam seq_t ISN          = 32'h0eadbeef;
	localparam int   WINDOW       = 1024;

	// Segment faults
	localparam int F_NONE  = 0;
	localparam int F_CSUM  = 1;		// One checksum bit flipped
	localparam int F_DROP  = 2;
	localparam int F_TRUNC = 3;		// Commit after three words
	localparam int F_SHORT = 4;		// Partial word inside header
	localparam int F_NOTCP = 5;

	localparam tcp_flags_t FL_SYN    = 4'b0010;	// ack rst syn fin
	localparam tcp_flags_t FL_SYNACK = 4'b1010;
	localparam tcp_flags_t FL_ACK    = 4'b1000;

	logic         clk;
	logic         rx_flag_rst;
	ip_addr_t     local_ip;
	logic         rx_start;
	ip_addr_t     rx_src_ip;
	logic [15:0]  rx_payload_len;
	logic         rx_is_tcp;
	csum_t        rx_pseudo_csum;
	logic         rx_data_valid;
	bytes_valid_t rx_bytes_valid;
	word_t        rx_data;
	logic         rx_commit;
	logic         rx_drop;
	logic         port_open_en;
	logic         port_close_en;
	port_num_t    port_num;
	logic         tx_start;
	ip_addr_t     tx_dst_ip;
	logic [15:0]  tx_payload_len;
	logic [7:0]   tx_protocol;
	logic         tx_data_valid;
	bytes_valid_t tx_bytes_valid;
	word_t        tx_data;
	logic         tx_commit;

	logic [31:0]  lfsr = 32'hab07f53b;
	reply_event_t exp_q [$];			// Replies still owed, in order
	port_num_t    model_tbl [256][4];	// Open ports, 0 = free way

	tcp_syn_responder #(
		.PORT_WAYS(4), .PORT_BINS(256), .ISN(ISN), .WINDOW(WINDOW)
	) dut (
		.clk(clk), .rx_flag_rst(rx_flag_rst), .local_ip(local_ip),
		.rx_start(rx_start), .rx_src_ip(rx_src_ip), .rx_payload_len(rx_payload_len),
		.rx_is_tcp(rx_is_tcp), .rx_pseudo_csum(rx_pseudo_csum),
		.rx_data_valid(rx_data_valid), .rx_bytes_valid(rx_bytes_valid),
		.rx_data(rx_data), .rx_commit(rx_commit), .rx_drop(rx_drop),
		.port_open_en(port_open_en), .port_close_en(port_close_en), .port_num(port_num),
		.tx_start(tx_start), .tx_dst_ip(tx_dst_ip), .tx_payload_len(tx_payload_len),
		.tx_protocol(tx_protocol), .tx_data_valid(tx_data_valid),
		.tx_bytes_valid(tx_bytes_valid), .tx_data(tx_data), .tx_commit(tx_commit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source, checksum arithmetic, port model

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	function automatic logic [31:0] add_word(input logic [31:0] acc, input word_t w);
		return acc + w[31:16] + w[15:0];	// Two 16-bit halves
	endfunction

	// End-around carry until it fits 16 bits
	function automatic csum_t fold_sum(input logic [31:0] acc);
		logic [31:0] a;
		a = acc;
		while (a[31:16] != 16'h0000)
			a = a[15:0] + a[31:16];
		return a[15:0];
	endfunction

	function automatic logic [31:0] pseudo_acc(input ip_addr_t src, input ip_addr_t dst,
			input logic [15:0] len);
		return add_word(add_word(add_word(32'd0, src), dst), {8'h00, IP_PROTO_TCP, len});
	endfunction

	function automatic logic model_has(input port_num_t p);
		logic hit;
		hit = 1'b0;
		for (int w = 0; w < 4; w++)
			if (p != '0 && model_tbl[p[7:0]][w] == p)
				hit = 1'b1;
		return hit;
	endfunction

	// Bin from low byte and no room in a full bin
	task automatic model_update(input logic open, input port_num_t p);
		logic done;
		done = model_has(p) || p == '0;
		for (int w = 0; w < 4; w++) begin
			if (open && !done && model_tbl[p[7:0]][w] == '0) begin
				model_tbl[p[7:0]][w] = p;
				done = 1'b1;
			end
			if (!open && p != '0 && model_tbl[p[7:0]][w] == p)
				model_tbl[p[7:0]][w] = '0;
		end
	endtask

	// Ports in bins 0x40..0x43 with eight per bin so bins fill up
	function automatic port_num_t pool_port();
		logic [2:0] hi;
		logic [1:0] lo;
		hi = 3'(rand_bits(3));
		lo = 2'(rand_bits(2));
		return {5'h00, hi, 6'h10, lo};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks

	task automatic end_with_errors();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic compare_ip(input string what, input ip_addr_t got, input ip_addr_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			end_with_errors();
		end
	endtask

	task automatic compare_port(input string what, input port_num_t got, input port_num_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			end_with_errors();
		end
	endtask

	task automatic compare_seq(input string what, input seq_t got, input seq_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			end_with_errors();
		end
	endtask

	task automatic compare_flags(input string what, input tcp_flags_t got,
			input tcp_flags_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
			end_with_errors();
		end
	endtask

	task automatic compare_csum(input string what, input csum_t got, input csum_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			end_with_errors();
		end
	endtask

	task automatic compare_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			end_with_errors();
		end
	endtask

	task automatic compare_bytes(input string what, input bytes_valid_t got,
			input bytes_valid_t exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
			end_with_errors();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reply checking

	task automatic check_reply(input word_t w [$], input ip_addr_t ip,
			input logic [15:0] len, input logic [7:0] proto);
		reply_event_t e;
		tcp_flags_t   f;
		word_t        exp_fw;
		logic [31:0]  acc;
		if (w.size() != 5) begin
			$display("Reply at %0t carried %0d words instead of five", $time, w.size());
			end_with_errors();
		end
		e      = exp_q.pop_front();
		exp_fw = '0;
		exp_fw[31:28]        = 4'd5;
		exp_fw[FLAG_ACK_BIT] = e.flags.ack;
		exp_fw[FLAG_RST_BIT] = e.flags.rst;
		exp_fw[FLAG_SYN_BIT] = e.flags.syn;
		exp_fw[FLAG_FIN_BIT] = e.flags.fin;
		exp_fw[15:0]         = 16'(WINDOW);
		f.ack = w[3][FLAG_ACK_BIT];
		f.rst = w[3][FLAG_RST_BIT];
		f.syn = w[3][FLAG_SYN_BIT];
		f.fin = w[3][FLAG_FIN_BIT];
		compare_ip("tx_dst_ip", ip, e.remote_ip);
		compare_word("length and protocol", {8'h00, proto, len}, {16'h0006, 16'd20});
		compare_port("reply src port", w[0][31:16], e.our_port);
		compare_port("reply dst port", w[0][15:0], e.remote_port);
		compare_seq("reply seq", w[1], e.seq);
		compare_seq("reply ack", w[2], e.ack);
		compare_flags("reply flags", f, e.flags);
		compare_word("offset/window word", w[3], exp_fw);
		acc = pseudo_acc(e.remote_ip, local_ip, 16'd20);
		acc = add_word(add_word(acc, {e.our_port, e.remote_port}), e.seq);
		acc = add_word(add_word(acc, e.ack), exp_fw);
		compare_csum("reply checksum", w[4][31:16], ~fold_sum(acc));
		// Whole segment with pseudo header must verify
		acc = pseudo_acc(ip, local_ip, len);
		foreach (w[i])
			acc = add_word(acc, w[i]);
		compare_csum("reply verify sum", ~fold_sum(acc), 16'h0000);
	endtask

	initial begin : tx_monitor
		word_t       got_words [$];
		ip_addr_t    got_ip;
		logic [15:0] got_len;
		logic [7:0]  got_proto;
		forever begin
			@(negedge clk);		// Outputs settled since posedge
			if (tx_start === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("Reply started at %0t with no SYN pending", $time);
					end_with_errors();
				end
				got_ip    = tx_dst_ip;
				got_len   = tx_payload_len;
				got_proto = tx_protocol;
				got_words.delete();
			end
			if (tx_data_valid === 1'b1) begin
				compare_bytes("tx_bytes_valid", tx_bytes_valid, bytes_valid_t'(4));
				got_words.push_back(tx_data);
			end
			if (tx_commit === 1'b1)
				check_reply(got_words, got_ip, got_len, got_proto);
		end
	end

	// Bound checker failures end the run
	initial begin : assertion_watch
		wait (dut.sva.fail_cnt != 0);
		$display("Bound assertion on handshake or framing failed at %0t", $time);
		end_with_errors();
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic port_cmd(input logic open, input port_num_t p);
		@(negedge clk);
		port_open_en  = open;
		port_close_en = !open;
		port_num      = p;
		@(negedge clk);
		port_open_en  = 1'b0;
		port_close_en = 1'b0;
		model_update(open, p);
	endtask

	task automatic send_segment(input ip_addr_t src, input port_num_t sport,
			input port_num_t dport, input seq_t seq, input tcp_flags_t fl,
			input int n_opts, input int n_body, input int fault);
		word_t        w [$];
		word_t        fw;
		logic [15:0]  len;
		logic [31:0]  acc;
		csum_t        field;
		int           n_send;
		reply_event_t e;
		len = 16'(4 * (5 + n_opts + n_body));
		fw  = '0;
		fw[31:28]        = 4'(5 + n_opts);
		fw[FLAG_ACK_BIT] = fl.ack;
		fw[FLAG_RST_BIT] = fl.rst;
		fw[FLAG_SYN_BIT] = fl.syn;
		fw[FLAG_FIN_BIT] = fl.fin;
		fw[15:0]         = 16'(rand_bits(16));	// Their window
		w.push_back({sport, dport});
		w.push_back(seq);
		w.push_back(rand_bits(32));				// Their ack field
		w.push_back(fw);
		w.push_back({16'h0000, 16'(rand_bits(16))});	// Checksum filled below
		for (int i = 0; i < n_opts + n_body; i++)
			w.push_back(rand_bits(32));
		acc = pseudo_acc(src, local_ip, len);
		foreach (w[i])
			acc = add_word(acc, w[i]);
		field = ~fold_sum(acc);
		if (fault == F_CSUM)
			field = field ^ 16'h0100;
		w[4][31:16] = field;

		// Only a clean plain SYN is answered
		if (fault == F_NONE && fl.syn && !fl.ack) begin
			e.remote_ip   = src;
			e.remote_port = sport;
			e.our_port    = dport;
			e.flags.ack   = 1'b1;
			e.flags.rst   = !model_has(dport);
			e.flags.syn   = model_has(dport);
			e.flags.fin   = 1'b0;
			e.seq         = model_has(dport) ? ISN : 32'd0;
			e.ack         = seq + 32'd1;
			exp_q.push_back(e);
		end

		n_send = (fault == F_TRUNC || fault == F_SHORT) ? 3 : w.size();
		@(negedge clk);
		rx_start       = 1'b1;
		rx_src_ip      = src;
		rx_payload_len = len;
		rx_is_tcp      = (fault != F_NOTCP);
		rx_pseudo_csum = fold_sum(pseudo_acc(src, local_ip, len));
		for (int i = 0; i < n_send; i++) begin
			@(negedge clk);
			rx_start       = 1'b0;
			rx_data_valid  = 1'b1;
			rx_bytes_valid = (fault == F_SHORT && i == 2) ? 3'd2 : 3'd4;
			rx_data        = w[i];
		end
		@(negedge clk);
		rx_data_valid  = 1'b0;
		rx_bytes_valid = '0;
		rx_data        = '0;
		if (fault == F_DROP)
			rx_drop = 1'b1;
		else
			rx_commit = 1'b1;
		@(negedge clk);
		rx_drop   = 1'b0;
		rx_commit = 1'b0;
		repeat (4 + rand_bits(3)) @(negedge clk);	// Handshake clears in 4
	endtask

	initial begin : watchdog
		#(CLK_PERIOD * (RST_CYCLES + NUM_SEGS * 200));
		$display("Timeout at %0t, replies still pending: %0d", $time, exp_q.size());
		end_with_errors();
	end

	initial begin : main
		tcp_flags_t fl;
		int         fault;
		int         kind;
		int         cmd;
		ip_addr_t   src;
		port_num_t  sport;
		port_num_t  dport;
		seq_t       seq;
		int         n_opts;
		int         n_body;
		foreach (model_tbl[b, w])
			model_tbl[b][w] = '0;
		rx_flag_rst    = 1'b1;
		local_ip       = 32'hc0a80a01;
		rx_start       = 1'b0;
		rx_src_ip      = '0;
		rx_payload_len = '0;
		rx_is_tcp      = 1'b0;
		rx_pseudo_csum = '0;
		rx_data_valid  = 1'b0;
		rx_bytes_valid = '0;
		rx_data        = '0;
		rx_commit      = 1'b0;
		rx_drop        = 1'b0;
		port_open_en   = 1'b0;
		port_close_en  = 1'b0;
		port_num       = '0;
		repeat (RST_CYCLES) @(negedge clk);
		rx_flag_rst = 1'b0;

		// Closed, opened, closed again
		send_segment(32'h0a000002, 16'd40000, 16'd80, 32'h10000000, FL_SYN, 0, 0, F_NONE);
		port_cmd(1'b1, 16'd80);
		send_segment(32'h0a000003, 16'd40001, 16'd80, 32'h20000000, FL_SYN, 0, 1, F_NONE);
		port_cmd(1'b0, 16'd80);
		send_segment(32'h0a000004, 16'd40002, 16'd80, 32'h30000000, FL_SYN, 1, 0, F_NONE);

		// Fill bin 0x34 so the fifth open is dropped
		for (int i = 1; i <= 5; i++)
			port_cmd(1'b1, {4'(i), 12'h234});
		send_segment(32'h0a000005, 16'd1111, 16'h5234, 32'h40000000, FL_SYN, 0, 0, F_NONE);
		send_segment(32'h0a000006, 16'd2222, 16'h4234, 32'h50000000, FL_SYN, 3, 2, F_NONE);

		// No reply for any of these
		send_segment(32'h0a000007, 16'd3333, 16'h4234, 32'h1, FL_SYN, 0, 1, F_CSUM);
		send_segment(32'h0a000007, 16'd3333, 16'h4234, 32'h2, FL_SYNACK, 0, 1, F_NONE);
		send_segment(32'h0a000007, 16'd3333, 16'h4234, 32'h3, FL_ACK, 0, 1, F_NONE);
		send_segment(32'h0a000007, 16'd3333, 16'h4234, 32'h4, FL_SYN, 2, 1, F_DROP);
		send_segment(32'h0a000007, 16'd3333, 16'h4234, 32'h5, FL_SYN, 0, 0, F_TRUNC);
		send_segment(32'h0a000007, 16'd3333, 16'h4234, 32'h6, FL_SYN, 0, 0, F_SHORT);
		send_segment(32'h0a000007, 16'd3333, 16'h4234, 32'h7, FL_SYN, 0, 0, F_NOTCP);

		// Longest options with an ack that wraps to zero
		send_segment(32'h0a000008, 16'd4444, 16'h1234, 32'hffffffff, FL_SYN, 10, 0, F_NONE);

		//////////////////////////////////////////////////////////////////////
		// Random traffic and port churn

		for (int n = 0; n < NUM_RAND; n++) begin
			kind = int'(rand_bits(3));
			cmd  = int'(rand_bits(2));
			if (cmd == 0)
				port_cmd(1'b1, pool_port());
			else if (cmd == 1)
				port_cmd(1'b0, pool_port());
			fl    = FL_SYN;
			fault = F_NONE;
			case (kind)
				4: fault = F_CSUM;
				5: fl = tcp_flags_t'(4'(rand_bits(4)));	// May still be a plain SYN
				6: fault = F_DROP;
				7: fault = F_TRUNC;
				default: ;
			endcase
			src    = rand_bits(32);
			sport  = 16'(rand_bits(16));
			dport  = pool_port();
			seq    = rand_bits(32);
			n_opts = int'(rand_bits(3));
			n_body = int'(rand_bits(2));
			send_segment(src, sport, dport, seq, fl, n_opts, n_body, fault);
		end

		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (40) @(negedge clk);		// Room for a stray reply to show
		if (dut.sva.fail_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== test/tcp_syn_responder_sva.sv ====
`timescale 1ns/10ps

module tcp_syn_responder_sva (
	input logic clk,
	input logic rx_flag_rst,
	input logic evt_req,
	input logic evt_ack,
	input logic tx_start,
	input logic tx_commit
);

	int fail_cnt = 0;	// Assertion failures so far

	//////////////////////////////////////////////////////////////////////
	// Four-phase reply handshake

	// Request stays up until the builder answers
	property req_holds_until_ack;
		@(posedge clk) disable iff (rx_flag_rst)
		evt_req && !evt_ack |=> evt_req;
	endproperty

	property ack_only_with_req;
		@(posedge clk) disable iff (rx_flag_rst)
		$rose(evt_ack) |-> evt_req;
	endproperty

	property no_req_while_ack;
		@(posedge clk) disable iff (rx_flag_rst)
		$rose(evt_req) |-> !evt_ack;	// Phase 4 must finish first
	endproperty

	//////////////////////////////////////////////////////////////////////
	// Output framing of five words then commit

	property commit_six_after_start;
		@(posedge clk) disable iff (rx_flag_rst)
		tx_start |=> !tx_commit [*5] ##1 tx_commit;
	endproperty

	a_req_hold:   assert property (req_holds_until_ack)
		else begin
			$error("evt_req dropped before evt_ack");
			fail_cnt++;
		end
	a_ack_req:    assert property (ack_only_with_req)
		else begin
			$error("evt_ack raised without evt_req");
			fail_cnt++;
		end
	a_req_ack:    assert property (no_req_while_ack)
		else begin
			$error("evt_req raised while evt_ack high");
			fail_cnt++;
		end
	a_tx_frame:   assert property (commit_six_after_start)
		else begin
			$error("tx_commit not six cycles after tx_start");
			fail_cnt++;
		end

endmodule

bind tcp_syn_responder tcp_syn_responder_sva sva (
	.clk(clk), .rx_flag_rst(rx_flag_rst),
	.evt_req(evt_req), .evt_ack(evt_ack),
	.tx_start(tx_start), .tx_commit(tx_commit)
);

// ==== hw/tcp_syn_responder.sv ====
`timescale 1ns/10ps

module tcp_syn_responder import tcp_pkg::*; #(
	parameter int   PORT_WAYS = 4,
	parameter int   PORT_BINS = 256,
	parameter seq_t ISN       = 32'h0eadbeef,
	parameter int   WINDOW    = 1024
) (
	input  logic         clk,
	input  logic         rx_flag_rst,
	input  ip_addr_t     local_ip,
	input  logic         rx_start,
	input  ip_addr_t     rx_src_ip,
	input  logic [15:0]  rx_payload_len,
	input  logic         rx_is_tcp,
	input  csum_t        rx_pseudo_csum,	// Uncomplemented pseudo header sum
	input  logic         rx_data_valid,
	input  bytes_valid_t rx_bytes_valid,
	input  word_t        rx_data,
	input  logic         rx_commit,
	input  logic         rx_drop,
	input  logic         port_open_en,
	input  logic         port_close_en,
	input  port_num_t    port_num,
	output logic         tx_start,
	output ip_addr_t     tx_dst_ip,
	output logic [15:0]  tx_payload_len,
	output logic [7:0]   tx_protocol,
	output logic         tx_data_valid,
	output bytes_valid_t tx_bytes_valid,
	output word_t        tx_data,
	output logic         tx_commit
);

	logic         check_en;
	port_num_t    check_port;
	logic         check_open;
	logic         rx_csum_zero;
	word_t        rx_csum_din;
	logic         evt_req;
	logic         evt_ack;
	reply_event_t evt;
	logic         tx_csum_clear;
	logic         tx_csum_add;
	word_t        tx_csum_din;
	csum_t        tx_csum_val;

	//////////////////////////////////////////////////////////////////////
	// Receive side

	// Pseudo header seeds the sum at start
	assign rx_csum_din = rx_data_valid ? rx_data : {16'h0000, rx_pseudo_csum};

	inet_checksum rx_csum (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.load(rx_start), .clear(1'b0), .add(rx_data_valid),
		.din(rx_csum_din), .csum(), .csum_zero(rx_csum_zero)
	);

	tcp_port_table #(.PORT_WAYS(PORT_WAYS), .PORT_BINS(PORT_BINS)) ports (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.open_en(port_open_en), .close_en(port_close_en), .port_num(port_num),
		.check_en(check_en), .check_port(check_port), .check_open(check_open)
	);

	tcp_rx_parser #(.ISN(ISN)) parser (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.rx_start(rx_start), .rx_data_valid(rx_data_valid),
		.rx_bytes_valid(rx_bytes_valid), .rx_data(rx_data),
		.rx_commit(rx_commit), .rx_drop(rx_drop), .rx_src_ip(rx_src_ip),
		.rx_payload_len(rx_payload_len), .rx_is_tcp(rx_is_tcp),
		.check_en(check_en), .check_port(check_port), .check_open(check_open),
		.csum_zero(rx_csum_zero),
		.evt_req(evt_req), .evt(evt), .evt_ack(evt_ack)
	);

	//////////////////////////////////////////////////////////////////////
	// Transmit side

	inet_checksum tx_csum (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.load(1'b0), .clear(tx_csum_clear), .add(tx_csum_add),
		.din(tx_csum_din), .csum(tx_csum_val), .csum_zero()
	);

	tcp_reply_tx #(.WINDOW(WINDOW)) reply (
		.clk(clk), .rx_flag_rst(rx_flag_rst), .local_ip(local_ip),
		.evt_req(evt_req), .evt(evt), .evt_ack(evt_ack),
		.csum_clear(tx_csum_clear), .csum_add(tx_csum_add),
		.csum_din(tx_csum_din), .csum(tx_csum_val),
		.tx_start(tx_start), .tx_dst_ip(tx_dst_ip),
		.tx_payload_len(tx_payload_len), .tx_protocol(tx_protocol),
		.tx_data_valid(tx_data_valid), .tx_bytes_valid(tx_bytes_valid),
		.tx_data(tx_data), .tx_commit(tx_commit)
	);

endmodule

// ==== hw/tcp_reply_tx.sv ====
`timescale 1ns/10ps

module tcp_reply_tx import tcp_pkg::*; #(
	parameter int WINDOW = 1024
) (
	input  logic         clk,
	input  logic         rx_flag_rst,
	input  ip_addr_t     local_ip,
	input  logic         evt_req,
	input  reply_event_t evt,
	output logic         evt_ack,
	output logic         csum_clear,
	output logic         csum_add,
	output word_t        csum_din,
	input  csum_t        csum,
	output logic         tx_start,
	output ip_addr_t     tx_dst_ip,
	output logic [15:0]  tx_payload_len,
	output logic [7:0]   tx_protocol,
	output logic         tx_data_valid,
	output bytes_valid_t tx_bytes_valid,
	output word_t        tx_data,
	output logic         tx_commit
);

	typedef enum logic [3:0] {
		T_IDLE,
		T_CLEAR,
		T_PSEUDO,
		T_PORT,
		T_SEQ,
		T_ACK,
		T_FLAGS,
		T_CSUM,
		T_COMMIT
	} state_t;

	state_t       state;
	logic [1:0]   pcnt;		// Pseudo header word 0..2
	reply_event_t ev_q;
	word_t        out_word;
	word_t        flags_word;
	word_t        pseudo_word;
	logic         accept;

	assign accept = (state == T_IDLE) && evt_req && !evt_ack;

	// IP layer side band, fixed for a header-only segment
	assign tx_dst_ip      = ev_q.remote_ip;
	assign tx_payload_len = TCP_HDR_BYTES;
	assign tx_protocol    = IP_PROTO_TCP;

	always_comb begin
		flags_word               = '0;
		flags_word[31:28]        = TCP_MIN_OFFSET;
		flags_word[FLAG_ACK_BIT] = ev_q.flags.ack;
		flags_word[FLAG_RST_BIT] = ev_q.flags.rst;
		flags_word[FLAG_SYN_BIT] = ev_q.flags.syn;
		flags_word[FLAG_FIN_BIT] = ev_q.flags.fin;
		flags_word[15:0]         = 16'(WINDOW);
		case (pcnt)		// Pseudo header words
			2'd0:    pseudo_word = ev_q.remote_ip;
			2'd1:    pseudo_word = local_ip;
			default: pseudo_word = {8'h00, IP_PROTO_TCP, TCP_HDR_BYTES};
		endcase
		case (state)
			T_PORT:  out_word = {ev_q.our_port, ev_q.remote_port};
			T_SEQ:   out_word = ev_q.seq;
			T_ACK:   out_word = ev_q.ack;
			T_FLAGS: out_word = flags_word;
			T_CSUM:  out_word = {csum, 16'h0000};	// Urgent pointer zero
			default: out_word = '0;
		endcase
	end

	assign csum_clear = (state == T_CLEAR);
	assign csum_add   = (state inside {T_PSEUDO, T_PORT, T_SEQ, T_ACK, T_FLAGS});
	assign csum_din   = (state == T_PSEUDO) ? pseudo_word : out_word;

	//////////////////////////////////////////////////////////////////////
	// Handshake and segment FSM

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			state          <= T_IDLE;
			pcnt           <= '0;
			evt_ack        <= 1'b0;
			tx_start       <= 1'b0;
			tx_data_valid  <= 1'b0;
			tx_bytes_valid <= '0;
			tx_commit      <= 1'b0;
		end else begin
			tx_start       <= 1'b0;
			tx_data_valid  <= 1'b0;
			tx_bytes_valid <= '0;
			tx_commit      <= 1'b0;
			if (evt_ack && !evt_req)
				evt_ack <= 1'b0;		// Phase 4

			case (state)
				T_IDLE: if (accept) begin
					evt_ack <= 1'b1;
					state   <= T_CLEAR;
				end
				T_CLEAR: begin
					pcnt  <= '0;
					state <= T_PSEUDO;
				end
				T_PSEUDO: begin
					pcnt <= pcnt + 2'd1;
					if (pcnt == 2'd2) begin
						tx_start <= 1'b1;	// First word one cycle later
						state    <= T_PORT;
					end
				end
				T_PORT, T_SEQ, T_ACK, T_FLAGS, T_CSUM: begin
					tx_data_valid  <= 1'b1;
					tx_bytes_valid <= bytes_valid_t'(4);
					state          <= state_t'(state + 4'd1);	// Next word in order
				end
				T_COMMIT: begin
					tx_commit <= 1'b1;
					state     <= T_IDLE;
				end
				default: state <= T_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			ev_q <= evt;
		tx_data <= out_word;	// Qualified by tx_data_valid
	end

endmodule

// ==== hw/tcp_rx_parser.sv ====
`timescale 1ns/10ps

module tcp_rx_parser import tcp_pkg::*; #(
	parameter seq_t ISN = 32'h0eadbeef
) (
	input  logic         clk,
	input  logic         rx_flag_rst,
	input  logic         rx_start,
	input  logic         rx_data_valid,
	input  bytes_valid_t rx_bytes_valid,
	input  word_t        rx_data,
	input  logic         rx_commit,
	input  logic         rx_drop,
	input  ip_addr_t     rx_src_ip,
	input  logic [15:0]  rx_payload_len,
	input  logic         rx_is_tcp,
	output logic         check_en,
	output port_num_t    check_port,	// Also our port for the reply
	input  logic         check_open,
	input  logic         csum_zero,
	output logic         evt_req,
	output reply_event_t evt,
	input  logic         evt_ack
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_PORT,
		S_SEQ,
		S_ACK,
		S_FLAGS,
		S_CSUM,
		S_OPTS,
		S_BODY,
		S_DECIDE
	} state_t;

	state_t    state;
	logic [3:0] hdr_cnt;		// Header words seen so far
	logic [3:0] offset_q;		// Data offset from the flags word
	ip_addr_t  src_ip_q;
	port_num_t rem_port_q;
	seq_t      seq_q;
	logic      rx_ack_q;
	logic      rx_syn_q;

	logic word_ok;		// Full 4-byte word
	logic hdr_state;	// Still inside the header
	logic want;			// Segment deserves a reply
	logic raise;		// Reply goes out this cycle

	assign word_ok   = rx_data_valid && (rx_bytes_valid == bytes_valid_t'(4));
	assign hdr_state = state inside {S_PORT, S_SEQ, S_ACK, S_FLAGS, S_CSUM, S_OPTS};
	assign want      = csum_zero && rx_syn_q && !rx_ack_q;	// Plain SYN only
	assign raise     = (state == S_DECIDE) && want && !evt_req && !evt_ack;

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			state    <= S_IDLE;
			hdr_cnt  <= '0;
			check_en <= 1'b0;
			evt_req  <= 1'b0;
		end else begin
			check_en <= 1'b0;
			if (evt_req && evt_ack)
				evt_req <= 1'b0;		// Phase 3 of the handshake

			if (hdr_state && word_ok)
				hdr_cnt <= hdr_cnt + 4'd1;

			case (state)
				S_IDLE: begin
					hdr_cnt <= '0;
					if (rx_start && rx_is_tcp && rx_payload_len >= TCP_HDR_BYTES)
						state <= S_PORT;
				end
				S_PORT: if (word_ok) begin
					check_en <= 1'b1;	// Look up dst port now
					state    <= S_SEQ;
				end
				S_SEQ:   if (word_ok) state <= S_ACK;
				S_ACK:   if (word_ok) state <= S_FLAGS;	// Their ack unused
				S_FLAGS: if (word_ok) state <= S_CSUM;
				S_CSUM: if (word_ok) begin
					// Checksum and urgent pointer skipped
					if (offset_q < TCP_MIN_OFFSET)
						state <= S_IDLE;		// Bogus offset
					else if (offset_q == TCP_MIN_OFFSET)
						state <= S_BODY;
					else
						state <= S_OPTS;
				end
				S_OPTS: if (word_ok && (hdr_cnt + 4'd1 == offset_q))
					state <= S_BODY;		// Last option word
				S_BODY: if (rx_commit)
					state <= S_DECIDE;
				S_DECIDE: begin
					if (!want || evt_req)
						state <= S_IDLE;		// Nothing to send, or lost like a packet
					else if (!evt_ack) begin
						evt_req <= 1'b1;
						state   <= S_IDLE;
					end
					// Else wait for evt_ack to drop
				end
				default: state <= S_IDLE;
			endcase

			// Truncated header or early commit
			if (hdr_state && (rx_commit || (rx_data_valid && !word_ok)))
				state <= S_IDLE;
			if (rx_drop && state != S_DECIDE)
				state <= S_IDLE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Header fields and reply event

	always_ff @(posedge clk) begin
		if (state == S_IDLE && rx_start)
			src_ip_q <= rx_src_ip;
		if (word_ok) begin
			case (state)
				S_PORT: begin
					rem_port_q <= rx_data[31:16];	// Their src port
					check_port <= rx_data[15:0];
				end
				S_SEQ: seq_q <= rx_data;
				S_FLAGS: begin
					offset_q <= rx_data[31:28];
					rx_ack_q <= rx_data[FLAG_ACK_BIT];
					rx_syn_q <= rx_data[FLAG_SYN_BIT];
				end
				default: ;
			endcase
		end
		if (raise) begin
			evt.remote_ip   <= src_ip_q;
			evt.remote_port <= rem_port_q;
			evt.our_port    <= check_port;
			evt.flags.ack   <= 1'b1;
			evt.flags.rst   <= !check_open;		// Closed port gets a reset
			evt.flags.syn   <= check_open;
			evt.flags.fin   <= 1'b0;
			evt.seq         <= check_open ? ISN : '0;
			evt.ack         <= seq_q + 32'd1;	// SYN takes one number
		end
	end

endmodule

// ==== hw/tcp_port_table.sv ====
`timescale 1ns/10ps

module tcp_port_table import tcp_pkg::*; #(
	parameter int PORT_WAYS = 4,
	parameter int PORT_BINS = 256
) (
	input  logic      clk,
	input  logic      rx_flag_rst,
	input  logic      open_en,
	input  logic      close_en,
	input  port_num_t port_num,
	input  logic      check_en,
	input  port_num_t check_port,
	output logic      check_open
);

	localparam int BIN_BITS = $clog2(PORT_BINS);
	localparam int WAY_BITS = (PORT_WAYS > 1) ? $clog2(PORT_WAYS) : 1;

	port_num_t tbl [PORT_BINS][PORT_WAYS];	// Port 0 = free way

	logic [BIN_BITS-1:0] cmd_bin;	// Bin from low port bits
	logic [BIN_BITS-1:0] chk_bin;
	logic [WAY_BITS-1:0] free_way;
	logic                cmd_present;
	logic                cmd_has_free;
	logic                chk_hit;

	assign cmd_bin = port_num[BIN_BITS-1:0];
	assign chk_bin = check_port[BIN_BITS-1:0];

	// Scan the command bin and the lookup bin
	always_comb begin
		cmd_present  = 1'b0;
		cmd_has_free = 1'b0;
		free_way     = '0;
		chk_hit      = 1'b0;
		for (int w = PORT_WAYS - 1; w >= 0; w--) begin	// Downward, lowest free way wins
			if (tbl[cmd_bin][w] == '0) begin
				cmd_has_free = 1'b1;
				free_way     = WAY_BITS'(w);
			end
			if (tbl[cmd_bin][w] == port_num)
				cmd_present = 1'b1;
			if (tbl[chk_bin][w] == check_port && check_port != '0)
				chk_hit = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			for (int b = 0; b < PORT_BINS; b++) begin
				for (int w = 0; w < PORT_WAYS; w++) begin
					tbl[b][w] <= '0;
				end
			end
			check_open <= 1'b0;
		end else begin
			if (open_en) begin		// Open wins over close
				if (port_num != '0 && !cmd_present && cmd_has_free)
					tbl[cmd_bin][free_way] <= port_num;	// Full bin drops the open
			end else if (close_en && port_num != '0) begin
				for (int w = 0; w < PORT_WAYS; w++) begin
					if (tbl[cmd_bin][w] == port_num)
						tbl[cmd_bin][w] <= '0;
				end
			end
			if (check_en)
				check_open <= chk_hit;	// Held until next check
		end
	end

endmodule

// ==== hw/inet_checksum.sv ====
`timescale 1ns/10ps

module inet_checksum import tcp_pkg::*; (
	input  logic  clk,
	input  logic  rx_flag_rst,
	input  logic  load,		// Sum <= din
	input  logic  clear,	// Sum <= 0
	input  logic  add,		// Sum <= sum + din
	input  word_t din,
	output csum_t csum,
	output logic  csum_zero
);

	csum_t sum;		// Folded ones-complement running sum

	// Fold up to two carry bits back into 16 bits
	function automatic csum_t fold(input logic [17:0] s);
		logic [16:0] t;
		t = 17'(s[15:0]) + 17'(s[17:16]);
		return t[15:0] + 16'(t[16]);	// Second carry cannot overflow again
	endfunction

	always_ff @(posedge clk) begin
		if (rx_flag_rst || clear) begin
			sum <= '0;
		end else if (load) begin
			sum <= fold(18'(din[31:16]) + 18'(din[15:0]));
		end else if (add) begin
			// Both halves of the word go in at once
			sum <= fold(18'(sum) + 18'(din[31:16]) + 18'(din[15:0]));
		end
	end

	assign csum      = ~sum;
	assign csum_zero = (csum == '0);	// All-ones sum, segment verifies

endmodule

// ==== hw/tcp_pkg.sv ====
package tcp_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and field types

	typedef logic [31:0] word_t;		// One stream word
	typedef logic [31:0] ip_addr_t;		// IPv4 address
	typedef logic [15:0] port_num_t;	// TCP port
	typedef logic [31:0] seq_t;			// Sequence or ack number
	typedef logic [15:0] csum_t;		// Internet checksum
	typedef logic [2:0]  bytes_valid_t;	// 0..4 valid bytes in a word

	//////////////////////////////////////////////////////////////////////
	// Protocol constants

	localparam logic [7:0]  IP_PROTO_TCP   = 8'd6;
	localparam logic [15:0] TCP_HDR_BYTES  = 16'd20;	// Fixed header, no options
	localparam logic [3:0]  TCP_MIN_OFFSET = 4'd5;		// Data offset in words

	// Flag positions inside the offset/flags/window word
	localparam int FLAG_ACK_BIT = 20;
	localparam int FLAG_RST_BIT = 18;
	localparam int FLAG_SYN_BIT = 17;
	localparam int FLAG_FIN_BIT = 16;

	typedef struct packed {
		logic ack;
		logic rst;
		logic syn;
		logic fin;
	} tcp_flags_t;

	//////////////////////////////////////////////////////////////////////
	// Header-only reply, parser to reply builder

	typedef struct packed {
		ip_addr_t   remote_ip;		// Becomes the IP destination
		port_num_t  remote_port;	// Their port, our dst port
		port_num_t  our_port;		// Our port, src port of the reply
		tcp_flags_t flags;
		seq_t       seq;			// Our sequence number
		seq_t       ack;			// Their seq + 1
	} reply_event_t;

endpackage
